//--- rv_core.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_stage_if.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -e '>>> FAIL' -e '%Error' $(LOG); then exit 1; fi
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
	localparam logic [31:0] SEED = 32'h4b7b;
	localparam logic [31:0] NOP = 32'h0000_0013;
	localparam logic [11:0] POISON_ADDR = 12'h300;
	localparam logic [11:0] DONE_ADDR = 12'h3f0;
	localparam int TIMEOUT = 1000;

	// operation kinds of the program model
	localparam int K_ADD = 0;
	localparam int K_SUB = 1;
	localparam int K_SLL = 2;
	localparam int K_SLT = 3;
	localparam int K_SLTU = 4;
	localparam int K_XOR = 5;
	localparam int K_SRL = 6;
	localparam int K_SRA = 7;
	localparam int K_OR = 8;
	localparam int K_AND = 9;

	logic        clk;
	logic        rst;
	logic [31:0] inst_addr;
	logic [31:0] inst;
	logic [31:0] mem_address;
	logic [31:0] mem_wdata;
	logic        dread;
	logic        dwrite;
	logic [31:0] mem_rdata;
	logic        stall;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] xr [32];
	logic [31:0] model_mem [256];
	int          pc_idx;
	int          errors;
	int          stall_cycles;
	logic        done_seen;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];

	rv_core #(
		.RESET_PC(32'h0)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.inst_addr(inst_addr),
		.inst(inst),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.dread(dread),
		.dwrite(dwrite),
		.mem_rdata(mem_rdata),
		.stall(stall)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("Fail %s expected %h actual %h", name, exp, act);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	// reference arithmetic straight from the ISA rules
	function automatic logic [31:0] model_op(input int k, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] y;
		case (k)
			K_ADD:   y = a + b;
			K_SUB:   y = a - b;
			K_SLL:   y = a << b[4:0];
			K_SLT:   y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			K_SLTU:  y = (a < b) ? 32'd1 : 32'd0;
			K_XOR:   y = a ^ b;
			K_SRL:   y = a >> b[4:0];
			K_SRA:   y = $unsigned($signed(a) >>> b[4:0]);
			K_OR:    y = a | b;
			default: y = a & b;
		endcase
		return y;
	endfunction

	function automatic logic [2:0] funct3_of(input int k);
		logic [2:0] f;
		case (k)
			K_ADD, K_SUB: f = 3'b000;
			K_SLL:        f = 3'b001;
			K_SLT:        f = 3'b010;
			K_SLTU:       f = 3'b011;
			K_XOR:        f = 3'b100;
			K_SRL, K_SRA: f = 3'b101;
			K_OR:         f = 3'b110;
			default:      f = 3'b111;
		endcase
		return f;
	endfunction

	function automatic logic [6:0] funct7_of(input int k);
		return (k == K_SUB || k == K_SRA) ? 7'b0100000 : 7'b0000000;
	endfunction

	task automatic put(input logic [31:0] w);
		imem[pc_idx] = w;
		pc_idx++;
	endtask

	task automatic do_r(input int k, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		put({funct7_of(k), rs2, rs1, funct3_of(k), rd, 7'b0110011});
		xr[rd] = model_op(k, xr[rs1], xr[rs2]);
	endtask

	task automatic do_i(input int k, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		logic [11:0] field;
		logic [31:0] b;
		field = imm;
		b = {{20{imm[11]}}, imm};
		// shifts carry funct7 in the upper immediate bits
		if (k == K_SLL || k == K_SRL || k == K_SRA) begin
			field = {funct7_of(k), imm[4:0]};
			b = {27'b0, imm[4:0]};
		end
		put({field, rs1, funct3_of(k), rd, 7'b0010011});
		xr[rd] = model_op(k, xr[rs1], b);
	endtask

	task automatic do_lui(input logic [4:0] rd, input logic [19:0] u);
		put({u, rd, 7'b0110111});
		xr[rd] = {u, 12'b0};
	endtask

	task automatic do_sw(input logic [4:0] rs2, input logic [11:0] off);
		put({off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011});
		model_mem[off[9:2]] = xr[rs2];
		exp_addr.push_back({20'b0, off});
		exp_data.push_back(xr[rs2]);
	endtask

	task automatic do_lw(input logic [4:0] rd, input logic [11:0] off);
		put({off, 5'd0, 3'b010, rd, 7'b0000011});
		xr[rd] = model_mem[off[9:2]];
	endtask

	task automatic do_br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off);
		put({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011});
	endtask

	task automatic build_program();
		logic [4:0] prev;
		logic [4:0] rd;
		logic [11:0] addr;
		int kinds_i [9];
		kinds_i = '{K_ADD, K_SLT, K_SLTU, K_XOR, K_OR, K_AND, K_SLL, K_SRL, K_SRA};
		pc_idx = 0;
		foreach (imem[i]) imem[i] = NOP;
		foreach (xr[i]) xr[i] = '0;
		// lui plus dependent addi
		do_lui(5'd1, 20'($urandom));
		do_i(K_ADD, 5'd1, 5'd1, 12'($urandom));
		do_sw(5'd1, 12'h100);
		do_lui(5'd2, 20'($urandom));
		do_i(K_ADD, 5'd2, 5'd2, 12'($urandom));
		do_sw(5'd2, 12'h104);
		// dependent chain with each result stored right away
		prev = 5'd1;
		rd = 5'd3;
		addr = 12'h110;
		for (int k = K_ADD; k <= K_AND; k++) begin
			do_r(k, rd, prev, 5'd2);
			do_sw(rd, addr);
			addr += 12'd4;
			prev = rd;
			rd = (rd == 5'd7) ? 5'd3 : rd + 5'd1;
		end
		foreach (kinds_i[i]) begin
			do_i(kinds_i[i], rd, prev, 12'($urandom));
			do_sw(rd, addr);
			addr += 12'd4;
			prev = rd;
			rd = (rd == 5'd7) ? 5'd3 : rd + 5'd1;
		end
		// load-use
		do_sw(5'd1, 12'h200);
		do_lw(5'd8, 12'h200);
		do_r(K_ADD, 5'd9, 5'd8, 5'd2);
		do_sw(5'd9, 12'h204);
		// taken beq over two poison stores and a not-taken bne
		do_i(K_ADD, 5'd10, 5'd0, 12'd5);
		do_i(K_ADD, 5'd11, 5'd0, 12'd5);
		do_br(3'b000, 5'd10, 5'd11, 13'd12);
		put({7'b0, 5'd1, 5'd0, 3'b010, POISON_ADDR[4:0], 7'b0100011} |
			{POISON_ADDR[11:5], 25'b0});
		put({7'b0, 5'd1, 5'd0, 3'b010, POISON_ADDR[4:0], 7'b0100011} |
			{POISON_ADDR[11:5], 25'b0});
		do_br(3'b001, 5'd10, 5'd11, 13'd8);
		do_sw(5'd10, 12'h304);
		do_sw(5'd0, DONE_ADDR);
	endtask

	// instruction and data memory models
	always begin
		logic [31:0] rdata;
		@(negedge clk);
		rdata = mem_rdata;
		if (stall === 1'b1) begin
			stall_cycles++;
		end
		if (dwrite === 1'b1) begin
			dmem[mem_address[9:2]] = mem_wdata;
			got_addr.push_back(mem_address);
			got_data.push_back(mem_wdata);
			if (mem_address == {20'b0, DONE_ADDR}) begin
				done_seen = 1'b1;
			end
		end
		if (dread === 1'b1) begin
			rdata = dmem[mem_address[9:2]];
		end
		@(posedge clk);
		#1;
		mem_rdata = rdata;
		inst = imem[inst_addr[9:2]];
	end

	initial begin
		int cycles;
		void'($urandom(SEED));
		rst = 1'b1;
		inst = NOP;
		mem_rdata = '0;
		errors = 0;
		stall_cycles = 0;
		done_seen = 1'b0;
		foreach (dmem[i]) dmem[i] = 32'h5a00_0000 ^ (i << 2);
		foreach (model_mem[i]) model_mem[i] = 32'h5a00_0000 ^ (i << 2);
		build_program();

		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			assert (inst_addr == 32'h0) else report_value("reset inst_addr", 32'h0, inst_addr);
			assert (!dread && !dwrite && !stall)
				else report_error("strobe or stall high during reset");
		end
		rst = 1'b0;
		assert (inst_addr == 32'h0) else report_value("post reset inst_addr", 32'h0, inst_addr);
		assert (!dread && !dwrite && !stall)
			else report_error("strobe or stall high right after reset");

		cycles = 0;
		while (!done_seen && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!done_seen) begin
			report_error("timeout waiting for the final store");
		end

		assert (got_addr.size() == exp_addr.size())
			else report_value("store count", exp_addr.size(), got_addr.size());
		for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
			assert (got_addr[i] == exp_addr[i])
				else report_value($sformatf("store %0d address", i), exp_addr[i], got_addr[i]);
			assert (got_data[i] == exp_data[i])
				else report_value($sformatf("store %0d data", i), exp_data[i], got_data[i]);
		end
		foreach (got_addr[i]) begin
			assert (got_addr[i] != {20'b0, POISON_ADDR})
				else report_error("store to the skipped address after a taken beq");
		end
		assert (stall_cycles == 1) else report_value("stall cycles", 32'd1, stall_cycles);
		if (u_dut.u_assert.fail_count != 0) begin
			report_error("a bound protocol assertion failed");
		end

		$display("checks done: %0d errors, %0d stores", errors, got_addr.size());
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end
endmodule

`default_nettype wire

//--- verification/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
	input wire        clk,
	input wire        rst,
	input wire        dread,
	input wire        dwrite,
	input wire        stall,
	input wire [31:0] mem_address
);
	int unsigned fail_count = 0;

	property no_read_write;
		@(posedge clk) disable iff (rst) !(dread && dwrite);
	endproperty

	property word_aligned;
		@(posedge clk) disable iff (rst) (dread || dwrite) |-> (mem_address[1:0] == 2'b00);
	endproperty

	// load-use costs a single bubble
	property single_stall;
		@(posedge clk) disable iff (rst) stall |=> !stall;
	endproperty

	// registers are clear from the second reset cycle on
	property quiet_in_reset;
		@(posedge clk) (rst ##1 rst) |-> (!dread && !dwrite && !stall);
	endproperty

	a_no_read_write: assert property (no_read_write) else begin
		fail_count++;
		$error("dread and dwrite together");
	end
	a_word_aligned: assert property (word_aligned) else begin
		fail_count++;
		$error("unaligned data address");
	end
	a_single_stall: assert property (single_stall) else begin
		fail_count++;
		$error("stall held two cycles");
	end
	a_quiet_in_reset: assert property (quiet_in_reset) else begin
		fail_count++;
		$error("activity during reset");
	end
endmodule

bind rv_core rv_core_assert u_assert (
	.clk(clk),
	.rst(rst),
	.dread(dread),
	.dwrite(dwrite),
	.stall(stall),
	.mem_address(mem_address)
);

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
	import rv_isa_pkg::*;
#(
	parameter rv_word RESET_PC = '0
) (
	input  logic   clk,
	input  logic   rst,
	output rv_word inst_addr,
	input  rv_word inst,
	output rv_word mem_address,
	output rv_word mem_wdata,
	output logic   dread,
	output logic   dwrite,
	input  rv_word mem_rdata,
	output logic   stall
);
	rv_word    if_pc;
	rv_word    if_inst;
	logic      redirect;
	rv_word    redirect_pc;
	logic      wb_en;
	rv_reg_idx wb_rd;
	rv_word    wb_data;

	rv_stage_if id_ex ();
	rv_stage_if ex_mem ();
	rv_stage_if mem_wb ();

	rv_fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.inst(inst),
		.inst_addr(inst_addr),
		.if_pc(if_pc),
		.if_inst(if_inst)
	);

	rv_decode u_decode (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.if_pc(if_pc),
		.if_inst(if_inst),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.id_ex(id_ex)
	);

	// EX/MEM is both written here and read back for forwarding
	rv_execute u_execute (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.ex_mem_fwd(ex_mem),
		.ex_mem(ex_mem),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	rv_memory u_memory (
		.clk(clk),
		.rst(rst),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.dread(dread),
		.dwrite(dwrite),
		.mem_rdata(mem_rdata),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);
endmodule

`default_nettype wire

//--- hdl/rv_memory.sv
`timescale 1ns/1ps
`default_nettype none

module rv_memory
	import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	rv_stage_if.consumer ex_mem,
	rv_stage_if.producer mem_wb,
	output rv_word    mem_address,
	output rv_word    mem_wdata,
	output logic      dread,
	output logic      dwrite,
	input  rv_word    mem_rdata,
	output logic      wb_en,
	output rv_reg_idx wb_rd,
	output rv_word    wb_data
);
	// address from the alu, store data from forwarded rs2
	assign mem_address = ex_mem.a;
	assign mem_wdata = ex_mem.b;
	assign dread = ex_mem.ctrl.valid && ex_mem.ctrl.mem_read;
	assign dwrite = ex_mem.ctrl.valid && ex_mem.ctrl.mem_write;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.ctrl <= '0;
		end else begin
			mem_wb.ctrl <= ex_mem.ctrl;
		end
	end

	always_ff @(posedge clk) begin
		mem_wb.pc <= ex_mem.pc;
		mem_wb.a <= ex_mem.a;
		mem_wb.b <= ex_mem.b;
	end

	assign wb_en = mem_wb.ctrl.valid && mem_wb.ctrl.reg_write;
	assign wb_rd = mem_wb.ctrl.rd;

	// read data shows up one cycle after dread
	always_comb begin
		case (mem_wb.ctrl.wb_sel)
			wb_u_imm: wb_data = mem_wb.ctrl.imm;
			wb_load:  wb_data = mem_rdata;
			default:  wb_data = mem_wb.a;
		endcase
	end
endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute
	import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	rv_stage_if.consumer id_ex,
	rv_stage_if.fwd      ex_mem_fwd,
	rv_stage_if.producer ex_mem,
	input  logic      wb_en,
	input  rv_reg_idx wb_rd,
	input  rv_word    wb_data,
	output logic      redirect,
	output rv_word    redirect_pc
);
	logic      ex_fwd_en;
	rv_reg_idx ex_fwd_rd;
	rv_word    ex_fwd_val;
	rv_word    rs1_fwd;
	rv_word    rs2_fwd;
	rv_word    opb;
	rv_word    alu_y;
	logic      rs_equal;
	logic      br_taken;

	// youngest producer wins
	function automatic rv_word fwd_pick(input rv_reg_idx src, input rv_word reg_val);
		rv_word val;
		if (ex_fwd_en && ex_fwd_rd == src) begin
			val = ex_fwd_val;
		end else if (wb_en && wb_rd == src) begin
			val = wb_data;
		end else begin
			val = reg_val;
		end
		return val;
	endfunction

	// loads in EX/MEM have no data to forward yet
	assign ex_fwd_en = ex_mem_fwd.ctrl.valid && ex_mem_fwd.ctrl.reg_write &&
		!ex_mem_fwd.ctrl.mem_read;
	assign ex_fwd_rd = ex_mem_fwd.ctrl.rd;
	assign ex_fwd_val = (ex_mem_fwd.ctrl.wb_sel == wb_u_imm) ? ex_mem_fwd.ctrl.imm :
		ex_mem_fwd.a;

	always_comb begin
		rs1_fwd = fwd_pick(id_ex.ctrl.rs1, id_ex.a);
		rs2_fwd = fwd_pick(id_ex.ctrl.rs2, id_ex.b);
	end

	always_comb begin
		case (id_ex.ctrl.opb_sel)
			opb_i_imm, opb_s_imm: opb = id_ex.ctrl.imm;
			default:              opb = rs2_fwd;
		endcase
	end

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add:  alu_y = rs1_fwd + opb;
			alu_sub:  alu_y = rs1_fwd - opb;
			alu_sll:  alu_y = rs1_fwd << opb[4:0];
			alu_slt:  alu_y = {31'b0, $signed(rs1_fwd) < $signed(opb)};
			alu_sltu: alu_y = {31'b0, rs1_fwd < opb};
			alu_xor:  alu_y = rs1_fwd ^ opb;
			alu_srl:  alu_y = rs1_fwd >> opb[4:0];
			alu_sra:  alu_y = rv_word'($signed(rs1_fwd) >>> opb[4:0]);
			alu_or:   alu_y = rs1_fwd | opb;
			default:  alu_y = rs1_fwd & opb;
		endcase
	end

	// beq and bne only
	assign rs_equal = (rs1_fwd == rs2_fwd);
	assign br_taken = id_ex.ctrl.valid && (id_ex.ctrl.opcode == op_br) &&
		((id_ex.ctrl.funct3 == br_bne) ? !rs_equal : rs_equal);

	assign redirect = br_taken;
	assign redirect_pc = id_ex.pc + id_ex.ctrl.imm;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.ctrl <= '0;
		end else begin
			ex_mem.ctrl <= id_ex.ctrl;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.pc <= id_ex.pc;
		ex_mem.a <= alu_y;
		ex_mem.b <= rs2_fwd;
	end
endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
	import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	output logic      stall,
	input  logic      redirect,
	input  rv_word    if_pc,
	input  rv_word    if_inst,
	input  logic      wb_en,
	input  rv_reg_idx wb_rd,
	input  rv_word    wb_data,
	rv_stage_if.producer id_ex
);
	ctrl_word_t dec;
	rv_opcode_e opcode;
	logic [2:0] funct3;
	rv_word     imm_i;
	rv_word     imm_s;
	rv_word     imm_b;
	rv_word     imm_u;
	rv_word     regs [32];
	rv_word     rs1_val;
	rv_word     rs2_val;
	logic       load_in_ex;

	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		alu_op_e op;
		case (rv_funct3_alu_e'(f3))
			f3_add_sub: op = (alt && is_reg) ? alu_sub : alu_add;
			f3_sll:     op = alu_sll;
			f3_slt:     op = alu_slt;
			f3_sltu:    op = alu_sltu;
			f3_xor:     op = alu_xor;
			f3_srl_sra: op = alt ? alu_sra : alu_srl;
			f3_or:      op = alu_or;
			default:    op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = rv_opcode_e'(if_inst[6:0]);
	assign funct3 = if_inst[14:12];
	assign imm_i = {{20{if_inst[31]}}, if_inst[31:20]};
	assign imm_s = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
	assign imm_b = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
		if_inst[11:8], 1'b0};
	assign imm_u = {if_inst[31:12], 12'b0};

	always_comb begin
		dec = '0;
		dec.opcode = opcode;
		dec.funct3 = funct3;
		dec.rs1 = if_inst[19:15];
		dec.rs2 = if_inst[24:20];
		dec.rd = if_inst[11:7];
		case (opcode)
			op_reg: begin
				dec.valid = 1'b1;
				dec.alu_op = alu_decode(funct3, if_inst[30], 1'b1);
				dec.rs1_used = 1'b1;
				dec.rs2_used = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_imm: begin
				dec.valid = 1'b1;
				dec.alu_op = alu_decode(funct3, if_inst[30], 1'b0);
				dec.opb_sel = opb_i_imm;
				dec.imm = imm_i;
				dec.rs1_used = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_lui: begin
				dec.valid = 1'b1;
				dec.wb_sel = wb_u_imm;
				dec.imm = imm_u;
				dec.reg_write = 1'b1;
			end
			op_load: begin
				dec.valid = (funct3 == FUNCT3_WORD);
				dec.opb_sel = opb_i_imm;
				dec.wb_sel = wb_load;
				dec.imm = imm_i;
				dec.rs1_used = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read = 1'b1;
			end
			op_store: begin
				dec.valid = (funct3 == FUNCT3_WORD);
				dec.opb_sel = opb_s_imm;
				dec.imm = imm_s;
				dec.rs1_used = 1'b1;
				dec.rs2_used = 1'b1;
				dec.mem_write = 1'b1;
			end
			op_br: begin
				dec.valid = (funct3 == br_beq) || (funct3 == br_bne);
				dec.alu_op = alu_sub;
				dec.imm = imm_b;
				dec.rs1_used = 1'b1;
				dec.rs2_used = 1'b1;
			end
			default: begin
			end
		endcase
		// unsupported encodings become bubbles
		if (!dec.valid) begin
			dec = '0;
		end
		dec.reg_write = dec.reg_write && (dec.rd != '0);
	end

	// register file, written from writeback
	always_ff @(posedge clk) begin
		if (wb_en) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// x0 reads zero, writeback value passes straight through
	assign rs1_val = (dec.rs1 == '0) ? '0 :
		(wb_en && wb_rd == dec.rs1) ? wb_data : regs[dec.rs1];
	assign rs2_val = (dec.rs2 == '0) ? '0 :
		(wb_en && wb_rd == dec.rs2) ? wb_data : regs[dec.rs2];

	// load result not ready until writeback
	assign load_in_ex = id_ex.ctrl.valid && id_ex.ctrl.mem_read && id_ex.ctrl.reg_write;
	assign stall = load_in_ex &&
		((dec.rs1_used && dec.rs1 == id_ex.ctrl.rd) ||
		(dec.rs2_used && dec.rs2 == id_ex.ctrl.rd));

	// ID/EX
	always_ff @(posedge clk) begin
		if (rst || stall || redirect) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex.ctrl <= dec;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc <= if_pc;
		id_ex.a <= rs1_val;
		id_ex.b <= rs2_val;
	end
endmodule

`default_nettype wire

//--- hdl/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
	import rv_isa_pkg::*;
#(
	parameter rv_word RESET_PC = '0
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   stall,
	input  logic   redirect,
	input  rv_word redirect_pc,
	input  rv_word inst,
	output rv_word inst_addr,
	output rv_word if_pc,
	output rv_word if_inst
);
	rv_word pc;

	assign inst_addr = pc;

	// predict not taken, branch target arrives from execute
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			if_inst <= NOP_INST;
		end else if (!stall) begin
			if_inst <= inst;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_pc <= pc;
		end
	end
endmodule

`default_nettype wire

//--- hdl/rv_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_stage_if
	import rv_isa_pkg::*, rv_pipe_pkg::*;
();
	ctrl_word_t ctrl;
	rv_word     pc;
	// operand or result pair, meaning depends on the stage
	rv_word     a;
	rv_word     b;

	modport producer (
		output ctrl,
		output pc,
		output a,
		output b
	);

	modport consumer (
		input ctrl,
		input pc,
		input a,
		input b
	);

	modport fwd (
		input ctrl,
		input a
	);
endinterface

`default_nettype wire

//--- hdl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;
	import rv_isa_pkg::*;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// second alu operand
	typedef enum logic [1:0] {
		opb_rs2,
		opb_i_imm,
		opb_s_imm
	} opb_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_u_imm,
		wb_load
	} wb_sel_e;

	// travels down the pipe with each instruction
	typedef struct packed {
		logic       valid;
		rv_opcode_e opcode;
		logic [2:0] funct3;
		alu_op_e    alu_op;
		opb_sel_e   opb_sel;
		wb_sel_e    wb_sel;
		rv_reg_idx  rs1;
		logic       rs1_used;
		rv_reg_idx  rs2;
		logic       rs2_used;
		rv_reg_idx  rd;
		logic       reg_write;
		logic       mem_read;
		logic       mem_write;
		rv_word     imm;
	} ctrl_word_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] rv_word;
	typedef logic [4:0] rv_reg_idx;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv_opcode_e;

	typedef enum logic [2:0] {
		br_beq = 3'b000,
		br_bne = 3'b001
	} rv_funct3_br_e;

	// funct3 shared by op_reg and op_imm
	typedef enum logic [2:0] {
		f3_add_sub = 3'b000,
		f3_sll     = 3'b001,
		f3_slt     = 3'b010,
		f3_sltu    = 3'b011,
		f3_xor     = 3'b100,
		f3_srl_sra = 3'b101,
		f3_or      = 3'b110,
		f3_and     = 3'b111
	} rv_funct3_alu_e;

	// lw and sw width
	localparam logic [2:0] FUNCT3_WORD = 3'b010;

	// addi x0, x0, 0
	localparam rv_word NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire
